//--- common/synth_pkg.sv
// note synthesizer types and register map
package synth_pkg;

    ////////////////////////////////////////
    // audio datapath
    ////////////////////////////////////////

    typedef logic [6:0]        note_t;    // piano key, 0..87
    typedef logic signed [7:0] sample_t;
    typedef logic [31:0]       freq_t;    // hz
    typedef logic [31:0]       phase_t;   // accumulator and step

    localparam int    LOG_SAMPLE_RATE = 17;   // about 131 khz
    localparam int    NOTE_COUNT      = 88;
    localparam freq_t DEFAULT_FREQ    = 32'd440;

    ////////////////////////////////////////
    // register map
    ////////////////////////////////////////

    localparam logic [7:0] ADDR_CTRL  = 8'h00;
    localparam logic [7:0] ADDR_STEP  = 8'h04;   // read only
    localparam logic [7:0] ADDR_PHASE = 8'h08;   // read only

    typedef struct packed {
        logic       enable;
        logic [2:0] volume;   // right shift of the sample
        note_t      note;
    } synth_ctrl_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

//--- common/display_pkg.sv
// seven-segment display definitions
package display_pkg;

    localparam int DIGITS = 8;

    typedef logic [3:0] nibble_t;
    typedef logic [6:0] segments_t;   // {g,f,e,d,c,b,a}, lit when high

    // hex digit patterns, 0 through f
    localparam segments_t SEG_TABLE [16] = '{
        7'b0111111,
        7'b0000110,
        7'b1011011,
        7'b1001111,
        7'b1100110,
        7'b1101101,
        7'b1111101,
        7'b0000111,
        7'b1111111,
        7'b1101111,
        7'b1110111,
        7'b1111100,
        7'b0111001,
        7'b1011110,
        7'b1111001,
        7'b1110001
    };

    typedef struct packed {
        logic [DIGITS-1:0] anode;     // active low, one digit at a time
        segments_t         cathode;   // active low
    } seg_drive_t;

endpackage

//--- verilog/apb_regs.sv
// apb control and status registers
`timescale 1ns/10ps

module apb_regs import synth_pkg::*; (
    input  logic        clk_in,
    input  logic        rst_in,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    output synth_ctrl_t ctrl,
    input  phase_t      step,
    input  phase_t      phase
);

    logic        access;    // second cycle of a transfer
    logic        addr_ok;
    logic        ro_write;  // write to a status address
    logic [31:0] ctrl_word;
    logic [31:0] rdata;

    assign access   = apb_req.psel & apb_req.penable;
    assign addr_ok  = (apb_req.paddr == ADDR_CTRL) ||
                      (apb_req.paddr == ADDR_STEP) ||
                      (apb_req.paddr == ADDR_PHASE);
    assign ro_write = apb_req.pwrite && (apb_req.paddr != ADDR_CTRL);

    // fields sit where they are written
    assign ctrl_word = {17'd0, ctrl.note, 1'b0, ctrl.volume, 3'd0, ctrl.enable};

    ////////////////////////////////////////
    // read mux
    ////////////////////////////////////////

    always_comb begin
        case (apb_req.paddr)
            ADDR_CTRL:  rdata = ctrl_word;
            ADDR_STEP:  rdata = step;
            ADDR_PHASE: rdata = phase;
            default:    rdata = 32'd0;
        endcase
    end

    assign apb_rsp = '{
        prdata:  (apb_req.psel && !apb_req.pwrite) ? rdata : 32'd0,
        pready:  access,                                  // no wait states
        pslverr: access && (!addr_ok || ro_write)
    };

    ////////////////////////////////////////
    // control register
    ////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ctrl <= '0;
        end else if (access && apb_req.pwrite && apb_req.paddr == ADDR_CTRL) begin
            ctrl.enable <= apb_req.pwdata[0];
            ctrl.volume <= apb_req.pwdata[6:4];
            ctrl.note   <= apb_req.pwdata[14:8];
        end
    end

endmodule

//--- tone/note_freq_rom.sv
// note to frequency table
`timescale 1ns/10ps

module note_freq_rom import synth_pkg::*; (
    input  logic  clk_in,
    input  note_t note,
    output freq_t freq
);

    // equal temperament from a0 upward in whole hz
    localparam freq_t FREQ_TABLE [NOTE_COUNT] = '{
          27,   29,   31,   33,   35,   37,   39,   41,   44,   46,
          49,   52,   55,   58,   62,   65,   69,   73,   78,   82,
          87,   92,   98,  104,  110,  117,  123,  131,  139,  147,
         156,  165,  175,  185,  196,  208,  220,  233,  247,  262,
         277,  294,  311,  330,  349,  370,  392,  415,  440,  466,
         494,  523,  554,  587,  622,  659,  698,  740,  784,  831,
         880,  932,  988, 1046, 1109, 1175, 1245, 1319, 1397, 1480,
        1568, 1661, 1760, 1865, 1976, 2093, 2217, 2349, 2489, 2637,
        2794, 2960, 3136, 3322, 3520, 3729, 3951, 4186
    };

    always_ff @(posedge clk_in) begin
        if (note < NOTE_COUNT) begin
            freq <= FREQ_TABLE[note];
        end else begin
            freq <= DEFAULT_FREQ;   // past the top key
        end
    end

endmodule

//--- tone/sine_rom.sv
// sine lookup table
`timescale 1ns/10ps

module sine_rom (
    input  logic       clk_in,
    input  logic [5:0] phase_index,
    output logic [7:0] amplitude
);

    // one full period, offset binary with 128 at zero
    localparam logic [7:0] SINE_TABLE [64] = '{
        128, 140, 152, 165, 176, 188, 198, 208,
        218, 226, 234, 240, 245, 250, 253, 254,
        255, 254, 253, 250, 245, 240, 234, 226,
        218, 208, 198, 188, 176, 165, 152, 140,
        128, 115, 103,  90,  79,  67,  57,  47,
         37,  29,  21,  15,  10,   5,   2,   1,
          0,   1,   2,   5,  10,  15,  21,  29,
         37,  47,  57,  67,  79,  90, 103, 115
    };

    always_ff @(posedge clk_in) begin
        amplitude <= SINE_TABLE[phase_index];
    end

endmodule

//--- tone/tone_generator.sv
// phase accumulator tone generator
`timescale 1ns/10ps

module tone_generator import synth_pkg::*; #(
    parameter int SAMPLE_DIV = 763
) (
    input  logic        clk_in,
    input  logic        rst_in,
    input  synth_ctrl_t ctrl,
    output phase_t      step,
    output phase_t      phase,
    output sample_t     sample
);

    localparam int TICK_W = $clog2(SAMPLE_DIV + 1);

    logic [TICK_W-1:0] tick_cnt;
    logic              tick;
    freq_t             freq;
    logic [7:0]        amplitude;
    sample_t           centered;

    note_freq_rom u_note_freq_rom (
        .clk_in (clk_in),
        .note   (ctrl.note),
        .freq   (freq)
    );

    // step = freq * 2^32 / 2^17, trimmed toward the real divider
    assign step = (freq << (32 - LOG_SAMPLE_RATE)) - (freq >> LOG_SAMPLE_RATE);

    ////////////////////////////////////////
    // sample tick and phase
    ////////////////////////////////////////

    assign tick = (tick_cnt == TICK_W'(SAMPLE_DIV));

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            tick_cnt <= '0;
            phase    <= '0;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            if (!ctrl.enable) begin
                phase <= '0;                // parked at mid scale
            end else if (tick) begin
                phase <= phase + step;      // wraps mod 2^32
            end
        end
    end

    sine_rom u_sine_rom (
        .clk_in      (clk_in),
        .phase_index (phase[31:26]),
        .amplitude   (amplitude)
    );

    assign centered = {~amplitude[7], amplitude[6:0]};  // offset binary to signed
    assign sample   = centered >>> ctrl.volume;

endmodule

//--- verilog/pwm_dac.sv
// audio pwm output
`timescale 1ns/10ps

module pwm_dac import synth_pkg::*; (
    input  logic    clk_in,
    input  logic    rst_in,
    input  sample_t sample,
    output logic    pwm
);

    logic [7:0] count;
    logic [7:0] level;

    assign level = {~sample[7], sample[6:0]};   // back to offset binary
    assign pwm   = (count < level);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            count <= 8'd0;
        end else begin
            count <= count + 8'd1;   // free running, period 256
        end
    end

endmodule

//--- verilog/seg_display.sv
// eight digit hex display scanner
`timescale 1ns/10ps

module seg_display import synth_pkg::*, display_pkg::*; #(
    parameter int SCAN_DIV = 100000
) (
    input  logic       clk_in,
    input  logic       rst_in,
    input  phase_t     value,
    output seg_drive_t drive
);

    localparam int SCAN_W = $clog2(SCAN_DIV + 1);

    logic [SCAN_W-1:0] scan_cnt;
    logic [DIGITS-1:0] digit_sel;   // one hot, bit 0 is the low nibble
    nibble_t           nibble;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            scan_cnt  <= '0;
            digit_sel <= DIGITS'(1);
        end else if (scan_cnt == SCAN_W'(SCAN_DIV)) begin
            scan_cnt  <= '0;
            digit_sel <= {digit_sel[DIGITS-2:0], digit_sel[DIGITS-1]};
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // nibble for the lit digit
    always_comb begin
        nibble = value[3:0];
        for (int i = 0; i < DIGITS; i++) begin
            if (digit_sel[i]) begin
                nibble = value[i*4 +: 4];
            end
        end
    end

    assign drive = '{
        anode:   ~digit_sel,
        cathode: ~SEG_TABLE[nibble]
    };

endmodule

//--- verilog/keyboard_top.sv
// note synthesizer top level
`timescale 1ns/10ps

module keyboard_top import synth_pkg::*, display_pkg::*; #(
    parameter int SAMPLE_DIV = 763,      // about 131 khz from 100 mhz
    parameter int SCAN_DIV   = 100000    // about 1 khz per digit
) (
    input  logic        clk_in,
    input  logic        rst_in,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    output logic        aud_pwm,
    output logic [15:0] led,
    output seg_drive_t  seg
);

    synth_ctrl_t ctrl;
    phase_t      step;
    phase_t      phase;
    sample_t     sample;

    apb_regs u_apb_regs (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .ctrl    (ctrl),
        .step    (step),
        .phase   (phase)
    );

    tone_generator #(
        .SAMPLE_DIV (SAMPLE_DIV)
    ) u_tone_generator (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .ctrl   (ctrl),
        .step   (step),
        .phase  (phase),
        .sample (sample)
    );

    pwm_dac u_pwm_dac (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .sample (sample),
        .pwm    (aud_pwm)
    );

    seg_display #(
        .SCAN_DIV (SCAN_DIV)
    ) u_seg_display (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .value  (step),
        .drive  (seg)
    );

    assign led = step[15:0];

endmodule

//--- testbench/keyboard_assert.sv
// apb and display assertions
`timescale 1ns/10ps

module keyboard_assert import synth_pkg::*, display_pkg::*; (
    input logic       clk_in,
    input logic       rst_in,
    input apb_req_t   apb_req,
    input apb_rsp_t   apb_rsp,
    input seg_drive_t seg
);

    int fail_count = 0;   // failed assertions so far

    // pready only in the access cycle
    ready_in_access: assert property (@(posedge clk_in) disable iff (rst_in)
        apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
        else begin
            $error("pready outside an access cycle");
            fail_count++;
        end

    error_with_ready: assert property (@(posedge clk_in) disable iff (rst_in)
        apb_rsp.pslverr |-> apb_rsp.pready)
        else begin
            $error("pslverr without pready");
            fail_count++;
        end

    ////////////////////////////////////////
    // display
    ////////////////////////////////////////

    one_digit_lit: assert property (@(posedge clk_in) disable iff (rst_in)
        $onehot(~seg.anode))   // exactly one anode low
        else begin
            $error("anode value does not have exactly one low bit");
            fail_count++;
        end

endmodule

//--- testbench/keyboard_tb.sv
// note synthesizer testbench
`timescale 1ns/10ps

module keyboard_tb import synth_pkg::*, display_pkg::*; ();

    localparam int SAMPLE_DIV  = 15;
    localparam int SCAN_DIV    = 3;
    localparam int RAND_CASES  = 4;
    localparam int STEP_SHIFT  = 32 - 17;   // 2^32 over a 2^17 sample rate

    // copy of the equal temperament table, a0 upward
    localparam int NOTE_HZ [88] = '{
          27,   29,   31,   33,   35,   37,   39,   41,   44,   46,
          49,   52,   55,   58,   62,   65,   69,   73,   78,   82,
          87,   92,   98,  104,  110,  117,  123,  131,  139,  147,
         156,  165,  175,  185,  196,  208,  220,  233,  247,  262,
         277,  294,  311,  330,  349,  370,  392,  415,  440,  466,
         494,  523,  554,  587,  622,  659,  698,  740,  784,  831,
         880,  932,  988, 1046, 1109, 1175, 1245, 1319, 1397, 1480,
        1568, 1661, 1760, 1865, 1976, 2093, 2217, 2349, 2489, 2637,
        2794, 2960, 3136, 3322, 3520, 3729, 3951, 4186
    };

    logic        clk_in;
    logic        rst_in;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        aud_pwm;
    logic [15:0] led;
    seg_drive_t  seg;

    logic [6:0]  case_note [$];
    logic [2:0]  case_vol [$];
    logic [31:0] case_step [$];
    int          cycle_count;
    int          timeout_limit;

    keyboard_top #(
        .SAMPLE_DIV (SAMPLE_DIV),
        .SCAN_DIV   (SCAN_DIV)
    ) u_keyboard_top (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .aud_pwm (aud_pwm),
        .led     (led),
        .seg     (seg)
    );

    bind keyboard_top keyboard_assert u_keyboard_assert (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .seg     (seg)
    );

    always #2 clk_in = ~clk_in;   // 4 ns period

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            fail_now("timeout: the run went past its cycle limit");
        end
    end

    always @(u_keyboard_top.u_keyboard_assert.fail_count) begin
        if (u_keyboard_top.u_keyboard_assert.fail_count != 0) begin
            fail_now("a bound assertion on apb or the display failed");
        end
    end

    function automatic logic [31:0] expected_step(input logic [6:0] note);
        logic [31:0] hz;
        hz = (note < 88) ? 32'(NOTE_HZ[note]) : 32'd440;   // above the top key
        return (hz << STEP_SHIFT) - (hz >> (32 - STEP_SHIFT));
    endfunction

    function automatic int low_anode_index();
        int idx;
        idx = 0;
        for (int i = 0; i < DIGITS; i++) begin
            if (!seg.anode[i]) idx = i;
        end
        return idx;
    endfunction

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic slverr);
        @(negedge clk_in);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(negedge clk_in);
        apb_req.penable = 1'b1;
        #1;
        assert (apb_rsp.pready) else fail_now("pready missing in a write access cycle");
        slverr = apb_rsp.pslverr;
        @(negedge clk_in);
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic slverr);
        @(negedge clk_in);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
        @(negedge clk_in);
        apb_req.penable = 1'b1;
        #1;
        assert (apb_rsp.pready) else fail_now("pready missing in a read access cycle");
        data   = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(negedge clk_in);
        apb_req = '0;
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen("testbench/keyboard_cases.txt", "r");
        if (fd == 0) fail_now("could not open testbench/keyboard_cases.txt");
        while (!$feof(fd)) begin
            if ($fgets(line, fd)) begin
                n = $sscanf(line, "%h %h %h", a, b, c);
                if (n == 3) begin   // comment and blank lines fall through
                    case_note.push_back(a[6:0]);
                    case_vol.push_back(b[2:0]);
                    case_step.push_back(c);
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic check_ctrl();
        logic [31:0] word;
        logic [31:0] rd;
        logic        err;
        word = {17'd0, 7'h2a, 1'b0, 3'd5, 3'd0, 1'b1};
        apb_write(ADDR_CTRL, word, err);
        assert (!err) else fail_now($sformatf("FAIL at %0t: pslverr on control write", $time));
        apb_read(ADDR_CTRL, rd, err);
        assert (rd == word && !err)
            else fail_now($sformatf("FAIL at %0t: ctrl read %h, expected %h", $time, rd, word));
        apb_write(ADDR_STEP, 32'hffff_ffff, err);
        assert (err) else fail_now($sformatf("FAIL at %0t: no pslverr on step write", $time));
        apb_read(8'd12, rd, err);
        assert (err) else fail_now($sformatf("FAIL at %0t: no pslverr at address 12", $time));
        apb_read(ADDR_CTRL, rd, err);
        assert (rd == word)
            else fail_now($sformatf("FAIL at %0t: ctrl changed to %h", $time, rd));
    endtask

    task automatic check_display(input logic [31:0] exp);
        int cur;
        int prev;
        int since;
        int moves;
        prev  = -1;
        since = 0;
        moves = 0;
        repeat (8 * (SCAN_DIV + 1) + 8) begin
            @(negedge clk_in);
            cur = low_anode_index();
            since++;
            assert (seg.cathode == ~SEG_TABLE[exp[cur*4 +: 4]])
                else fail_now($sformatf("FAIL at %0t: cathode %b on digit %0d",
                                        $time, seg.cathode, cur));
            if (prev >= 0 && cur != prev) begin
                assert (cur == (prev + 1) % DIGITS)
                    else fail_now($sformatf("FAIL at %0t: digit %0d after %0d",
                                            $time, cur, prev));
                // the first interval is seen only in part
                if (moves > 0) begin
                    assert (since == SCAN_DIV + 1)
                        else fail_now($sformatf("FAIL at %0t: digit held %0d cycles",
                                                $time, since));
                end
                moves++;
                since = 0;
            end
            prev = cur;
        end
        assert (moves >= DIGITS)
            else fail_now($sformatf("FAIL at %0t: display moved only %0d times",
                                    $time, moves));
    endtask

    task automatic check_step(input logic [6:0] note, input logic [2:0] vol,
                              input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_write(ADDR_CTRL, {17'd0, note, 1'b0, vol, 3'd0, 1'b1}, err);
        apb_read(ADDR_STEP, rd, err);
        assert (rd == exp && !err)
            else fail_now($sformatf("FAIL at %0t: note %0d step %h, expected %h",
                                    $time, note, rd, exp));
        assert (led == exp[15:0])
            else fail_now($sformatf("FAIL at %0t: led %h, expected %h", $time, led, exp[15:0]));
        check_display(exp);
    endtask

    task automatic check_phase();
        logic [31:0] p1;
        logic [31:0] p2;
        logic [31:0] lsb;
        logic [31:0] step;
        logic        err;
        step = expected_step(7'd48);
        lsb  = step & (~step + 32'd1);   // multiples share the low zero bits
        // park the phase at zero on the new note before enabling
        apb_write(ADDR_CTRL, {17'd0, 7'd48, 1'b0, 3'd0, 3'd0, 1'b0}, err);
        apb_write(ADDR_CTRL, {17'd0, 7'd48, 1'b0, 3'd0, 3'd0, 1'b1}, err);
        apb_read(ADDR_PHASE, p1, err);
        repeat (SAMPLE_DIV + 2) @(negedge clk_in);
        apb_read(ADDR_PHASE, p2, err);
        assert (p1 != p2) else fail_now($sformatf("FAIL at %0t: phase stuck at %h", $time, p1));
        assert ((p1 & (lsb - 1)) == 0 && (p2 & (lsb - 1)) == 0)
            else fail_now($sformatf("FAIL at %0t: phase %h %h not a step multiple",
                                    $time, p1, p2));
    endtask

    task automatic check_silence();
        logic [31:0] rd;
        logic        err;
        int          high;
        apb_write(ADDR_CTRL, 32'd0, err);
        repeat (4) @(negedge clk_in);
        apb_read(ADDR_PHASE, rd, err);
        assert (rd == 0) else fail_now($sformatf("FAIL at %0t: phase %h while off", $time, rd));
        high = 0;
        repeat (256) begin
            @(negedge clk_in);
            if (aud_pwm) high++;
        end
        assert (high == 128)
            else fail_now($sformatf("FAIL at %0t: pwm high %0d of 256", $time, high));
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        logic [6:0] note;
        void'($urandom(47));
        clk_in        = 1'b0;
        rst_in        = 1'b1;
        apb_req       = '0;
        cycle_count   = 0;
        timeout_limit = 2000;
        load_cases();
        timeout_limit = 200 * (case_note.size() + RAND_CASES + 3) + 2000;
        repeat (3) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        check_ctrl();
        foreach (case_note[i]) begin
            check_step(case_note[i], case_vol[i], case_step[i]);
        end
        repeat (RAND_CASES) begin
            note = 7'($urandom % 128);
            check_step(note, 3'($urandom % 8), expected_step(note));
        end
        check_phase();
        check_silence();

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- testbench/keyboard_cases.txt
# note volume step, all in hex
# note is the piano key index, step the expected phase step
00 0 000d8000
0c 1 001b8000
27 2 00830000
30 0 00dc0000
3c 3 01b80000
46 4 03100000
4b 5 04168000
57 6 082d0000
64 7 00dc0000
7f 0 00dc0000

//--- sim.f
common/synth_pkg.sv
common/display_pkg.sv
verilog/apb_regs.sv
tone/note_freq_rom.sv
tone/sine_rom.sv
tone/tone_generator.sv
verilog/pwm_dac.sv
verilog/seg_display.sv
verilog/keyboard_top.sv
testbench/keyboard_assert.sv
testbench/keyboard_tb.sv
